// ==== list.f ====
+incdir+include
source/muldiv_pkg.sv
source/muldiv_regfile.sv
source/muldiv_mul.sv
source/muldiv_div.sv
source/muldiv_wb.sv
source/muldiv_core.sv
tb/muldiv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module muldiv_tb -f list.f -o muldiv_sim \
    && ./obj_dir/muldiv_sim | tee sim.log \
    || { echo "Build or simulation failed"; exit 1; }
grep -q "All tests passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tb/muldiv_tb.sv ====
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module muldiv_tb;
    import muldiv_pkg::*;

    localparam int n_instr     = 80;
    localparam int watchdog_ns = n_instr * 200 * 100;

    logic                clk;
    logic                rst;
    logic                issue_valid;
    issue_t              issue;
    logic                load_valid;
    logic [4:0]          load_rd;
    logic [`MD_XLEN-1:0] load_data;
    logic                issue_ready;
    logic                retire_valid;
    retire_t             retire;
    logic                idle;

    logic [`MD_XLEN-1:0] shadow [`MD_NREGS];
    retire_t             exp_q [$];
    logic [63:0]         next_pc;
    int                  errors;
    int                  err_mark;
    int                  n_pass;
    int                  n_fail;

    muldiv_core i_muldiv_core (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue(issue),
        .load_valid(load_valid), .load_rd(load_rd), .load_data(load_data),
        .issue_ready(issue_ready), .retire_valid(retire_valid), .retire(retire),
        .idle(idle)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout after %0d ns, the DUT stopped retiring", watchdog_ns);
        $display("Some tests failed");
        $finish;
    end

    // Expected result from the RISC-V M extension rules
    function automatic logic [63:0] ref_muldiv(input logic [2:0] f, input logic w,
                                               input logic [63:0] a, input logic [63:0] b);
        logic [127:0]       pa;
        logic [127:0]       pb;
        logic [127:0]       p;
        logic [63:0]        xa;
        logic [63:0]        xb;
        logic signed [63:0] sxa;
        logic signed [63:0] sxb;
        logic [63:0]        q;
        logic [63:0]        rm;
        logic [63:0]        r;
        if (!f[2]) begin
            pa = (f == 3'b001 || f == 3'b010) ? {{64{a[63]}}, a} : {64'd0, a};
            pb = (f == 3'b001) ? {{64{b[63]}}, b} : {64'd0, b};
            p  = pa * pb;
            r  = (f == 3'b000) ? p[63:0] : p[127:64];
        end else begin
            if (w) begin
                xa = !f[0] ? {{32{a[31]}}, a[31:0]} : {32'd0, a[31:0]};
                xb = !f[0] ? {{32{b[31]}}, b[31:0]} : {32'd0, b[31:0]};
            end else begin
                xa = a;
                xb = b;
            end
            sxa = xa;
            sxb = xb;
            if (xb == 64'd0) begin
                q  = '1;
                rm = xa;
            end else if (!f[0] && xa == 64'h8000_0000_0000_0000 && xb == '1) begin
                q  = xa;
                rm = 64'd0;
            end else if (!f[0]) begin
                q  = sxa / sxb;
                rm = sxa % sxb;
            end else begin
                q  = xa / xb;
                rm = xa % xb;
            end
            r = f[1] ? rm : q;
        end
        if (w) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return r;
    endfunction

    function automatic logic pending(input logic [63:0] pc_nxt);
        logic found;
        found = 1'b0;
        foreach (exp_q[i]) begin
            if (exp_q[i].pc_nxt == pc_nxt) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Comparator, matched by rd and pc_nxt
    always @(posedge clk) begin
        int      idx;
        retire_t e;
        if (rst && retire_valid) begin
            idx = -1;
            foreach (exp_q[i]) begin
                if (idx < 0 && exp_q[i].rd == retire.rd && exp_q[i].pc_nxt == retire.pc_nxt) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                $display("Retire at %0t with rd %0d and pc_nxt %h matches no issued instruction",
                         $time, retire.rd, retire.pc_nxt);
                errors++;
            end else begin
                e = exp_q[idx];
                exp_q.delete(idx);
                if (retire.error != e.error) begin
                    $display("ERROR %0t retire.error: got %b expected %b",
                             $time, retire.error, e.error);
                    errors++;
                end
                if (retire.wen != e.wen) begin
                    $display("ERROR %0t retire.wen: got %b expected %b", $time, retire.wen, e.wen);
                    errors++;
                end
                if (!e.error && retire.data != e.data) begin
                    $display("ERROR %0t retire.data: got %h expected %h",
                             $time, retire.data, e.data);
                    errors++;
                end
            end
        end
    end

    task automatic send(input logic [31:0] instr, input retire_t e);
        @(negedge clk);
        issue_valid = 1'b1;
        issue.pc    = e.pc_nxt - 64'd4;
        issue.instr = instr;
        do begin
            @(posedge clk);
        end while (!issue_ready);
        exp_q.push_back(e);
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic issue_m(input logic [2:0] f, input logic w, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
        retire_t     e;
        logic [31:0] instr;
        instr    = {`MD_F7_MULDIV, rs2, rs1, f, rd, (w ? `MD_OPC_OP32 : `MD_OPC_OP)};
        e.pc_nxt = next_pc + 64'd4;
        e.rd     = rd;
        e.data   = ref_muldiv(f, w, shadow[rs1], shadow[rs2]);
        e.wen    = (rd != 5'd0);
        e.error  = 1'b0;
        next_pc  = next_pc + 64'd4;
        if (rd != 5'd0) begin
            shadow[rd] = e.data;
        end
        send(instr, e);
    endtask

    // Words outside the M extension carry no destination
    task automatic issue_illegal(input logic [31:0] instr);
        retire_t e;
        e.pc_nxt = next_pc + 64'd4;
        e.rd     = 5'd0;
        e.data   = '0;
        e.wen    = 1'b0;
        e.error  = 1'b1;
        next_pc  = next_pc + 64'd4;
        send(instr, e);
    endtask

    task automatic preload(input logic [4:0] rd, input logic [63:0] data);
        @(negedge clk);
        load_valid = 1'b1;
        load_rd    = rd;
        load_data  = data;
        @(negedge clk);
        load_valid = 1'b0;
        if (rd != 5'd0) begin
            shadow[rd] = data;
        end
    endtask

    // All issued work retired, scoreboard and units must be free again
    task automatic drain();
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0);
        @(negedge clk);
        if (idle != 1'b1) begin
            $display("ERROR %0t idle: got %b expected 1", $time, idle);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            n_pass++;
            $display("PASS  %s", name);
        end else begin
            n_fail++;
            $display("FAIL  %s", name);
        end
        err_mark = errors;
    endtask

    initial begin
        logic [63:0] v;
        logic [2:0]  f;
        logic [63:0] mul_pc;
        int          k;
        void'($urandom(40474));
        rst         = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        load_valid  = 1'b0;
        load_rd     = 5'd0;
        load_data   = '0;
        errors      = 0;
        err_mark    = 0;
        n_pass      = 0;
        n_fail      = 0;
        next_pc     = 64'h8000_0000;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        @(negedge clk);
        if (retire_valid != 1'b0) begin
            $display("ERROR %0t retire_valid: got %b expected 0", $time, retire_valid);
            errors++;
        end
        if (idle != 1'b1) begin
            $display("ERROR %0t idle: got %b expected 1", $time, idle);
            errors++;
        end
        // Every third register gets a small signed value
        for (int r = 1; r < 32; r++) begin
            v = {$urandom, $urandom};
            if (r % 3 == 0) begin
                v = {{48{v[15]}}, v[15:0]};
            end
            preload(5'(r), v);
        end
        for (int n = 0; n < 40; n++) begin
            issue_m(3'(n % 8), 1'b0, (n == 3) ? 5'd0 : 5'($urandom % 32),
                    5'($urandom % 32), 5'($urandom % 32));
        end
        drain();
        end_test("reset and full-width operations");

        for (int n = 0; n < 20; n++) begin
            f = (n % 5 == 0) ? 3'b000 : 3'(3 + n % 5);
            issue_m(f, 1'b1, 5'(1 + $urandom % 31), 5'($urandom % 32), 5'($urandom % 32));
        end
        drain();
        end_test("W forms");

        preload(5'd1, 64'h8000_0000_0000_0000);
        preload(5'd2, '1);
        preload(5'd3, 64'd0);
        preload(5'd4, {$urandom, $urandom});
        preload(5'd5, 64'h1234_5678_8000_0000);
        k = 10;
        for (int w = 0; w < 2; w++) begin
            for (int d = 4; d < 8; d++) begin
                issue_m(3'(d), 1'(w), 5'(k), 5'd4, 5'd3);
                k++;
            end
            issue_m(3'b100, 1'(w), 5'(k), (w == 1) ? 5'd5 : 5'd1, 5'd2);
            issue_m(3'b110, 1'(w), 5'(k + 1), (w == 1) ? 5'd5 : 5'd1, 5'd2);
            k += 2;
        end
        drain();
        end_test("divide by zero and overflow");

        mul_pc = next_pc + 64'd4;
        issue_m(3'b000, 1'b0, 5'd22, 5'd4, 5'd5);
        issue_m(3'b100, 1'b0, 5'd23, 5'd1, 5'd4);
        if (!pending(mul_pc)) begin
            $display("MUL retired before the DIV was issued, the units never overlapped");
            errors++;
        end
        drain();
        end_test("parallel units");

        mul_pc = next_pc + 64'd4;
        issue_m(3'b000, 1'b0, 5'd24, 5'd4, 5'd5);
        issue_m(3'b100, 1'b0, 5'd25, 5'd24, 5'd4);
        if (pending(mul_pc)) begin
            $display("DIV was issued while the MUL it reads from was still pending");
            errors++;
        end
        issue_m(3'b110, 1'b0, 5'd24, 5'd25, 5'd5);
        drain();
        end_test("dependency");

        issue_illegal(32'h0000_0013);
        issue_m(3'b000, 1'b0, 5'd26, 5'd4, 5'd5);
        // MULH encoding under OP32 does not exist
        issue_illegal({`MD_F7_MULDIV, 5'd2, 5'd1, 3'b001, 5'd0, `MD_OPC_OP32});
        drain();
        end_test("illegal words");

        $display("Tests passed %0d, failed %0d, check errors %0d", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== source/muldiv_core.sv ====
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module muldiv_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  muldiv_pkg::issue_t   issue,
    input  logic                 load_valid,
    input  logic [4:0]           load_rd,
    input  logic [`MD_XLEN-1:0]  load_data,
    output logic                 issue_ready,
    output logic                 retire_valid,
    output muldiv_pkg::retire_t  retire,
    output logic                 idle
);
    import muldiv_pkg::*;

    logic [6:0]           opcode;
    logic [6:0]           funct7;
    logic [2:0]           funct3;
    logic [4:0]           rd;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic                 is_op32;
    logic                 legal;
    logic                 to_div;
    logic                 unit_ready;
    logic                 fire;
    logic [`MD_XLEN-1:0]  rs1_data;
    logic [`MD_XLEN-1:0]  rs2_data;
    logic                 rs1_busy;
    logic                 rs2_busy;
    logic [`MD_NREGS-1:0] busy;
    unit_op_t             uop;
    logic                 mul_ready;
    logic                 mul_start;
    logic                 mul_valid;
    logic                 mul_grant;
    unit_result_t         mul_res;
    logic                 div_ready;
    logic                 div_start;
    logic                 div_valid;
    logic                 div_grant;
    unit_result_t         div_res;
    logic                 trap_valid;
    logic                 trap_grant;
    logic [`MD_XLEN-1:0]  trap_pc_nxt;

    assign opcode = issue.instr[6:0];
    assign rd     = issue.instr[11:7];
    assign funct3 = issue.instr[14:12];
    assign rs1    = issue.instr[19:15];
    assign rs2    = issue.instr[24:20];
    assign funct7 = issue.instr[31:25];

    // OP32 has no MULH variants
    assign is_op32 = (opcode == `MD_OPC_OP32);
    assign legal   = (funct7 == `MD_F7_MULDIV) &&
                     ((opcode == `MD_OPC_OP) || (is_op32 && (funct3 == 3'b000 || funct3[2])));
    assign to_div  = funct3[2];

    assign unit_ready  = legal ? (to_div ? div_ready : mul_ready) : !trap_valid;
    assign issue_ready = unit_ready && !rs1_busy && !rs2_busy && !busy[rd];
    assign fire        = issue_valid && issue_ready;
    assign mul_start   = fire && legal && !to_div;
    assign div_start   = fire && legal && to_div;

    always_comb begin
        uop.funct = m_funct_t'(funct3);
        uop.is_w  = is_op32;
        uop.rd    = rd;
        uop.a     = rs1_data;
        uop.b     = rs2_data;
        uop.pc    = issue.pc;
    end

    // One-entry trap slot for words outside the M extension
    always_ff @(posedge clk) begin
        if (!rst) begin
            trap_valid <= 1'b0;
        end else if (fire && !legal) begin
            trap_valid <= 1'b1;
        end else if (trap_grant) begin
            trap_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !legal) begin
            trap_pc_nxt <= issue.pc + `MD_XLEN'(4);
        end
    end

    assign idle = !(|busy) && mul_ready && div_ready && !trap_valid;

    muldiv_regfile i_regfile (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2),
        .wb(retire), .wb_valid(retire_valid),
        .mark_valid(fire && legal), .mark_rd(rd),
        .load_valid(load_valid), .load_rd(load_rd), .load_data(load_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy), .rd_busy_any(busy)
    );

    muldiv_mul i_mul (
        .clk(clk), .rst(rst), .start(mul_start), .op(uop), .grant(mul_grant),
        .ready(mul_ready), .res_valid(mul_valid), .res(mul_res)
    );

    muldiv_div i_div (
        .clk(clk), .rst(rst), .start(div_start), .op(uop), .grant(div_grant),
        .ready(div_ready), .res_valid(div_valid), .res(div_res)
    );

    muldiv_wb i_wb (
        .clk(clk), .rst(rst),
        .mul_valid(mul_valid), .mul_res(mul_res),
        .div_valid(div_valid), .div_res(div_res),
        .trap_valid(trap_valid), .trap_pc_nxt(trap_pc_nxt),
        .mul_grant(mul_grant), .div_grant(div_grant), .trap_grant(trap_grant),
        .retire_valid(retire_valid), .retire(retire)
    );

endmodule

// ==== source/muldiv_wb.sv ====
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module muldiv_wb (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mul_valid,
    input  muldiv_pkg::unit_result_t mul_res,
    input  logic                     div_valid,
    input  muldiv_pkg::unit_result_t div_res,
    input  logic                     trap_valid,
    input  logic [`MD_XLEN-1:0]      trap_pc_nxt,
    output logic                     mul_grant,
    output logic                     div_grant,
    output logic                     trap_grant,
    output logic                     retire_valid,
    output muldiv_pkg::retire_t      retire
);
    import muldiv_pkg::*;

    unit_result_t win;

    // Multiplier first, then divider, then trap slot
    assign mul_grant  = mul_valid;
    assign div_grant  = div_valid && !mul_valid;
    assign trap_grant = trap_valid && !mul_valid && !div_valid;
    assign win        = mul_valid ? mul_res : div_res;

    always_ff @(posedge clk) begin
        if (!rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= mul_valid || div_valid || trap_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (trap_grant) begin
            retire.pc_nxt <= trap_pc_nxt;
            retire.rd     <= 5'd0;
            retire.data   <= '0;
            retire.wen    <= 1'b0;
            retire.error  <= 1'b1;
        end else begin
            retire.pc_nxt <= win.pc_nxt;
            retire.rd     <= win.rd;
            retire.data   <= win.data;
            retire.wen    <= (win.rd != 5'd0);
            retire.error  <= 1'b0;
        end
    end

endmodule

// ==== source/muldiv_div.sv ====
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module muldiv_div (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  muldiv_pkg::unit_op_t     op,
    input  logic                     grant,
    output logic                     ready,
    output logic                     res_valid,
    output muldiv_pkg::unit_result_t res
);
    import muldiv_pkg::*;

    localparam int XL = `MD_XLEN;
    localparam int HW = `MD_XLEN / 2;
    localparam int CW = $clog2(`MD_STEPS);

    unit_state_t     state;
    logic [CW-1:0]   cnt;
    logic            last;
    unit_op_t        op_q;
    logic [XL-1:0]   quot;
    logic [XL-1:0]   rem;
    logic [XL-1:0]   dvs;

    logic            is_signed;
    logic            is_rem;
    logic            sa;
    logic            sb;
    logic [XL-1:0]   a_ext;
    logic [XL-1:0]   b_ext;
    logic [XL-1:0]   a_mag;
    logic [XL-1:0]   b_mag;
    logic [XL:0]     rem_sh;
    logic [XL:0]     diff;
    logic [XL-1:0]   quot_nxt;
    logic [XL-1:0]   rem_nxt;
    logic [XL-1:0]   q_fix;
    logic [XL-1:0]   r_fix;
    logic [XL-1:0]   sel;
    logic [XL-1:0]   data_nxt;

    always_comb begin
        is_signed = !op_q.funct[0];
        is_rem    = op_q.funct[1];

        // W operands are extended to 64 bits, the upper steps then shift in zeros
        if (op_q.is_w) begin
            a_ext = is_signed ? {{HW{op_q.a[HW-1]}}, op_q.a[HW-1:0]}
                              : {{HW{1'b0}}, op_q.a[HW-1:0]};
            b_ext = is_signed ? {{HW{op_q.b[HW-1]}}, op_q.b[HW-1:0]}
                              : {{HW{1'b0}}, op_q.b[HW-1:0]};
        end else begin
            a_ext = op_q.a;
            b_ext = op_q.b;
        end
        sa    = is_signed && a_ext[XL-1];
        sb    = is_signed && b_ext[XL-1];
        a_mag = sa ? -a_ext : a_ext;
        b_mag = sb ? -b_ext : b_ext;

        // Restoring step
        rem_sh   = {rem, quot[XL-1]};
        diff     = rem_sh - {1'b0, dvs};
        quot_nxt = {quot[XL-2:0], !diff[XL]};
        rem_nxt  = diff[XL] ? rem_sh[XL-1:0] : diff[XL-1:0];

        // Overflow falls out of the magnitudes, only zero needs a patch
        q_fix = (sa ^ sb) ? -quot_nxt : quot_nxt;
        r_fix = sa ? -rem_nxt : rem_nxt;
        if (dvs == '0) begin
            sel = is_rem ? op_q.a : '1;
        end else begin
            sel = is_rem ? r_fix : q_fix;
        end
        data_nxt = op_q.is_w ? {{HW{sel[HW-1]}}, sel[HW-1:0]} : sel;
    end

    assign last = (cnt == CW'(`MD_STEPS - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= s_idle;
            cnt   <= '0;
        end else begin
            case (state)
                s_idle:  if (start) state <= s_load;
                s_load:  state <= s_run;
                s_run:   if (last) state <= s_done;
                s_done:  if (grant) state <= s_idle;
                default: state <= s_idle;
            endcase
            cnt <= (state == s_run) ? cnt + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && start) begin
            op_q <= op;
        end
        if (state == s_load) begin
            quot <= a_mag;
            rem  <= '0;
            dvs  <= b_mag;
        end
        if (state == s_run) begin
            quot <= quot_nxt;
            rem  <= rem_nxt;
            if (last) begin
                res.rd     <= op_q.rd;
                res.data   <= data_nxt;
                res.pc_nxt <= op_q.pc + XL'(4);
            end
        end
    end

    assign ready     = (state == s_idle);
    assign res_valid = (state == s_done);

endmodule

// ==== source/muldiv_mul.sv ====
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module muldiv_mul (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  muldiv_pkg::unit_op_t     op,
    input  logic                     grant,
    output logic                     ready,
    output logic                     res_valid,
    output muldiv_pkg::unit_result_t res
);
    import muldiv_pkg::*;

    localparam int XL = `MD_XLEN;
    localparam int HW = `MD_XLEN / 2;
    localparam int CW = $clog2(`MD_STEPS);

    unit_state_t       state;
    logic [CW-1:0]     cnt;
    logic              last;
    unit_op_t          op_q;
    logic [XL-1:0]     mcand;
    logic [2*XL-1:0]   prod;

    logic              a_signed;
    logic              b_signed;
    logic              neg;
    logic [XL-1:0]     a_in;
    logic [XL-1:0]     b_in;
    logic [XL-1:0]     a_mag;
    logic [XL-1:0]     b_mag;
    logic [XL:0]       sum;
    logic [2*XL-1:0]   prod_nxt;
    logic [2*XL-1:0]   prod_fix;
    logic [XL-1:0]     data_nxt;

    // W form multiplies the low words, only the low half is kept
    always_comb begin
        a_signed = !op_q.is_w && (op_q.funct == f_mulh || op_q.funct == f_mulhsu);
        b_signed = !op_q.is_w && op_q.funct == f_mulh;
        a_in     = op_q.is_w ? {{HW{1'b0}}, op_q.a[HW-1:0]} : op_q.a;
        b_in     = op_q.is_w ? {{HW{1'b0}}, op_q.b[HW-1:0]} : op_q.b;
        neg      = (a_signed && a_in[XL-1]) ^ (b_signed && b_in[XL-1]);
        a_mag    = (a_signed && a_in[XL-1]) ? -a_in : a_in;
        b_mag    = (b_signed && b_in[XL-1]) ? -b_in : b_in;

        // One shift-add step, multiplier sits in the low half
        sum      = {1'b0, prod[2*XL-1:XL]} + (prod[0] ? {1'b0, mcand} : '0);
        prod_nxt = {sum, prod[XL-1:1]};
        prod_fix = neg ? -prod_nxt : prod_nxt;

        if (op_q.is_w) begin
            data_nxt = {{HW{prod_fix[HW-1]}}, prod_fix[HW-1:0]};
        end else if (op_q.funct == f_mul) begin
            data_nxt = prod_fix[XL-1:0];
        end else begin
            data_nxt = prod_fix[2*XL-1:XL];
        end
    end

    assign last = (cnt == CW'(`MD_STEPS - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= s_idle;
            cnt   <= '0;
        end else begin
            case (state)
                s_idle:  if (start) state <= s_load;
                s_load:  state <= s_run;
                s_run:   if (last) state <= s_done;
                s_done:  if (grant) state <= s_idle;
                default: state <= s_idle;
            endcase
            cnt <= (state == s_run) ? cnt + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && start) begin
            op_q <= op;
        end
        if (state == s_load) begin
            mcand <= b_mag;
            prod  <= {{XL{1'b0}}, a_mag};
        end
        if (state == s_run) begin
            prod <= prod_nxt;
            if (last) begin
                res.rd     <= op_q.rd;
                res.data   <= data_nxt;
                res.pc_nxt <= op_q.pc + XL'(4);
            end
        end
    end

    assign ready     = (state == s_idle);
    assign res_valid = (state == s_done);

endmodule

// ==== source/muldiv_regfile.sv ====
`timescale 1ns/1ps
`include "muldiv_defs.svh"

module muldiv_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [4:0]            rs1,
    input  logic [4:0]            rs2,
    input  muldiv_pkg::retire_t   wb,
    input  logic                  wb_valid,
    input  logic                  mark_valid,
    input  logic [4:0]            mark_rd,
    input  logic                  load_valid,
    input  logic [4:0]            load_rd,
    input  logic [`MD_XLEN-1:0]   load_data,
    output logic [`MD_XLEN-1:0]   rs1_data,
    output logic [`MD_XLEN-1:0]   rs2_data,
    output logic                  rs1_busy,
    output logic                  rs2_busy,
    output logic [`MD_NREGS-1:0]  rd_busy_any
);

    logic [`MD_XLEN-1:0]  regs [`MD_NREGS];
    logic [`MD_NREGS-1:0] busy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `MD_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Preload happens only while idle, so it never meets a writeback
            if (load_valid && load_rd != 5'd0) begin
                regs[load_rd] <= load_data;
            end
            if (wb_valid && wb.wen) begin
                regs[wb.rd] <= wb.data;
            end
        end
    end

    // Scoreboard
    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= '0;
        end else begin
            if (wb_valid && wb.wen) begin
                busy[wb.rd] <= 1'b0;
            end
            if (mark_valid && mark_rd != 5'd0) begin
                busy[mark_rd] <= 1'b1;
            end
        end
    end

    assign rs1_data    = regs[rs1];
    assign rs2_data    = regs[rs2];
    assign rs1_busy    = busy[rs1];
    assign rs2_busy    = busy[rs2];
    assign rd_busy_any = busy;

endmodule

// ==== source/muldiv_pkg.sv ====
`include "muldiv_defs.svh"

package muldiv_pkg;

    // funct3 of the M extension
    typedef enum logic [2:0] {
        f_mul    = 3'b000,
        f_mulh   = 3'b001,
        f_mulhsu = 3'b010,
        f_mulhu  = 3'b011,
        f_div    = 3'b100,
        f_divu   = 3'b101,
        f_rem    = 3'b110,
        f_remu   = 3'b111
    } m_funct_t;

    // Shared by both iterative units
    typedef enum logic [1:0] {
        s_idle,
        s_load,
        s_run,
        s_done
    } unit_state_t;

    typedef struct packed {
        logic [`MD_XLEN-1:0] pc;
        logic [31:0]         instr;
    } issue_t;

    typedef struct packed {
        m_funct_t            funct;
        logic                is_w;
        logic [4:0]          rd;
        logic [`MD_XLEN-1:0] a;
        logic [`MD_XLEN-1:0] b;
        logic [`MD_XLEN-1:0] pc;
    } unit_op_t;

    typedef struct packed {
        logic [4:0]          rd;
        logic [`MD_XLEN-1:0] data;
        logic [`MD_XLEN-1:0] pc_nxt;
    } unit_result_t;

    typedef struct packed {
        logic [`MD_XLEN-1:0] pc_nxt;
        logic [4:0]          rd;
        logic [`MD_XLEN-1:0] data;
        logic                wen;
        logic                error;
    } retire_t;

endpackage

// ==== include/muldiv_defs.svh ====
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// Datapath and register file size
`define MD_XLEN  64
`define MD_NREGS 32

// Shift-add and restoring steps per operation
`define MD_STEPS 64

// Major opcodes of the integer register forms
`define MD_OPC_OP   7'b0110011
`define MD_OPC_OP32 7'b0111011

// funct7 of the M extension
`define MD_F7_MULDIV 7'b0000001

`endif
